//--- hdl/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

  // ####################
  // command word
  // ####################

  // flag in bit 15, address in bits 14 to 8, data byte in bits 7 to 0
  localparam int CMD_WIDTH = 16;
  localparam int RW_BIT    = 15;

  // values of the flag bit
  localparam logic CMD_WRITE = 1'b1;
  localparam logic CMD_READ  = 1'b0;

  // ####################
  // types
  // ####################

  typedef logic [CMD_WIDTH-1:0] cmd_t;  // one host command

endpackage

`default_nettype wire

//--- hdl/cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer #(
  parameter int BR       = 434,
  parameter int GAP_BITS = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  input  cmd_pkg::cmd_t       cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  output uart_cfg_pkg::data_t read_data,
  output logic                read_rdy,
  tx_frame_if.sequencer       txf,
  rx_frame_if.sequencer       rxf
);

  localparam int GAP_CYC = GAP_BITS * BR;
  localparam int GAP_W   = $clog2(GAP_CYC);

  typedef logic [GAP_W-1:0] gap_t;

  typedef enum logic [2:0] {
    IDLE,
    LAUNCH,
    SEND_HI,
    GAP,
    SEND_LO,
    WAIT_RX,
    FINISH
  } state_t;

  state_t        state;
  cmd_pkg::cmd_t cmd_buf;
  gap_t          gap_cnt;
  logic          start;
  logic          accept;
  logic          reply_good;

  assign accept     = cmd_vld && cmd_rdy;
  assign reply_good = (state == WAIT_RX) && rxf.valid && rxf.parity_ok;

  // the low byte goes out only in the second frame of a write
  assign txf.start  = start;
  assign txf.data   = (state == SEND_LO) ? cmd_buf[uart_cfg_pkg::DATA_BITS-1:0]
                                         : cmd_buf[cmd_pkg::CMD_WIDTH-1 -: uart_cfg_pkg::DATA_BITS];
  assign rxf.enable = (state == WAIT_RX);

  // ####################
  // command FSM
  // ####################
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      start   <= 1'b0;
      gap_cnt <= '0;
    end
    else
    begin
      start <= 1'b0;
      unique case (state)
        IDLE:
          if (accept)
            state <= LAUNCH;
        LAUNCH:
          if (!txf.busy)
          begin
            start <= 1'b1;
            state <= SEND_HI;
          end
        SEND_HI:
          if (txf.done)
          begin
            gap_cnt <= '0;
            case (cmd_buf[cmd_pkg::RW_BIT])
              cmd_pkg::CMD_WRITE: state <= GAP;
              cmd_pkg::CMD_READ:  state <= WAIT_RX;
              default:            state <= IDLE;
            endcase
          end
        GAP:
          // start is registered, so it is raised one cycle before the gap ends
          if (gap_cnt == gap_t'(GAP_CYC - 2))
          begin
            start <= 1'b1;
            state <= SEND_LO;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        SEND_LO:
          if (txf.done)
            state <= FINISH;
        WAIT_RX:
          if (rxf.valid)
            state <= FINISH;  // a reply with bad parity ends the read as well
        FINISH:
          state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_buf <= cmd_in;
  end

  // ready comes back one cycle after the FSM is idle again
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cmd_rdy <= 1'b1;
    else if (accept)
      cmd_rdy <= 1'b0;
    else if (state == IDLE)
      cmd_rdy <= 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_data <= '0;
      read_rdy  <= 1'b0;
    end
    else
    begin
      read_rdy <= reply_good;
      if (reply_good)
        read_data <= rxf.data;
    end
  end

endmodule

`default_nettype wire

//--- hdl/frame_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// link from the sequencer to the serializer
interface tx_frame_if;
  logic                start;  // one-cycle launch request
  uart_cfg_pkg::data_t data;   // byte to send, sampled with start
  logic                busy;   // high for the whole frame
  logic                done;   // last cycle of the stop bit

  modport sequencer (
    output start,
    output data,
    input  busy,
    input  done
  );

  modport engine (
    input  start,
    input  data,
    output busy,
    output done
  );
endinterface

// link from the deserializer to the sequencer
interface rx_frame_if;
  logic                enable;     // the line is watched only while this is high
  uart_cfg_pkg::data_t data;       // received byte
  logic                valid;      // one-cycle pulse per frame
  logic                parity_ok;  // qualifies data in the valid cycle

  modport sequencer (
    output enable,
    input  data,
    input  valid,
    input  parity_ok
  );

  modport engine (
    input  enable,
    output data,
    output valid,
    output parity_ok
  );
endinterface

`default_nettype wire

//--- hdl/uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

  // ####################
  // frame layout
  // ####################

  // one start bit, the data bits, one even parity bit and one stop bit
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = 11;

  // bit counters have to reach FRAME_BITS - 1
  localparam int BIT_CNT_W  = 4;

  // ####################
  // payload
  // ####################

  typedef logic [DATA_BITS-1:0] data_t;  // a single byte on the line

endpackage

`default_nettype wire

//--- hdl/uart_cmd_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge #(
  parameter int BR       = 434,
  parameter int GAP_BITS = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  input  cmd_pkg::cmd_t       cmd_in,
  input  logic                cmd_vld,
  input  logic                rx,
  output logic                tx,
  output logic                cmd_rdy,
  output uart_cfg_pkg::data_t read_data,
  output logic                read_rdy
);

  tx_frame_if txf ();
  rx_frame_if rxf ();

  // ####################
  // command side
  // ####################
  cmd_sequencer #(
    .BR       (BR),
    .GAP_BITS (GAP_BITS)
  ) u_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .txf       (txf.sequencer),
    .rxf       (rxf.sequencer)
  );

  // ####################
  // line side
  // ####################
  uart_tx_frame #(
    .BR (BR)
  ) u_tx_frame (
    .clk   (clk),
    .rst_n (rst_n),
    .txf   (txf.engine),
    .tx    (tx)
  );

  uart_rx_frame #(
    .BR (BR)
  ) u_rx_frame (
    .clk   (clk),
    .rst_n (rst_n),
    .rxf   (rxf.engine),
    .rx    (rx)
  );

endmodule

`default_nettype wire

//--- hdl/uart_rx_frame.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_frame #(
  parameter int BR = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  rx_frame_if.engine rxf,
  input  logic       rx
);

  localparam int BAUD_W = $clog2(BR);

  typedef logic [BAUD_W-1:0]                  baud_t;
  typedef logic [uart_cfg_pkg::BIT_CNT_W-1:0] bit_idx_t;

  localparam bit_idx_t FIRST_DATA = bit_idx_t'(1);
  localparam bit_idx_t LAST_DATA  = bit_idx_t'(uart_cfg_pkg::DATA_BITS);
  localparam bit_idx_t PAR_SLOT   = bit_idx_t'(uart_cfg_pkg::DATA_BITS + 1);
  localparam bit_idx_t STOP_SLOT  = bit_idx_t'(uart_cfg_pkg::FRAME_BITS - 1);

  logic                rx_meta;
  logic                rx_sync;
  logic                rx_prev;
  logic                active;
  baud_t               baud_cnt;
  bit_idx_t            bit_cnt;
  uart_cfg_pkg::data_t shift_reg;
  logic                parity;
  logic                parity_ok;
  logic                valid;
  logic                start_edge;
  logic                mid_bit;
  logic                data_slot;

  assign start_edge = rxf.enable && !active && rx_prev && !rx_sync;
  assign mid_bit    = active && (baud_cnt == baud_t'(BR / 2));
  assign data_slot  = (bit_cnt >= FIRST_DATA) && (bit_cnt <= LAST_DATA);

  assign rxf.data      = shift_reg;
  assign rxf.valid     = valid;
  assign rxf.parity_ok = parity_ok;

  // two flops against metastability and a third one for the edge
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // ####################
  // frame control
  // ####################
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      valid    <= 1'b0;
    end
    else
    begin
      valid <= 1'b0;
      if (!rxf.enable)
        active <= 1'b0;
      else if (start_edge)
      begin
        active   <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
      else if (active)
      begin
        if (baud_cnt == baud_t'(BR - 1))
        begin
          baud_cnt <= '0;
          bit_cnt  <= bit_cnt + 1'b1;
        end
        else
          baud_cnt <= baud_cnt + 1'b1;
        if (mid_bit)
        begin
          if (bit_cnt == '0 && rx_sync)
            active <= 1'b0;  // a line that is high again at mid-bit was only a glitch
          else if (bit_cnt == STOP_SLOT)
          begin
            active <= 1'b0;
            valid  <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start_edge)
      parity <= 1'b0;
    else if (mid_bit && data_slot)
    begin
      shift_reg <= {rx_sync, shift_reg[uart_cfg_pkg::DATA_BITS-1:1]};
      parity    <= parity ^ rx_sync;
    end
    else if (mid_bit && bit_cnt == PAR_SLOT)
      parity_ok <= (rx_sync == parity);  // even parity over the data bits
  end

endmodule

`default_nettype wire

//--- hdl/uart_tx_frame.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_frame #(
  parameter int BR = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  tx_frame_if.engine txf,
  output logic       tx
);

  localparam int BAUD_W = $clog2(BR);

  typedef logic [BAUD_W-1:0]                  baud_t;
  typedef logic [uart_cfg_pkg::BIT_CNT_W-1:0] bit_idx_t;

  localparam bit_idx_t LAST_BIT  = bit_idx_t'(uart_cfg_pkg::FRAME_BITS - 1);
  localparam bit_idx_t PAR_SLOT  = bit_idx_t'(uart_cfg_pkg::DATA_BITS);

  baud_t               baud_cnt;
  bit_idx_t            bit_cnt;
  uart_cfg_pkg::data_t shift_reg;
  logic                parity;
  logic                busy;
  logic                load;
  logic                bit_end;
  logic                next_is_data;

  assign load         = txf.start && !busy;
  assign bit_end      = busy && (baud_cnt == baud_t'(BR - 1));
  assign next_is_data = bit_cnt < PAR_SLOT;  // bits 0 to 7 are followed by a data bit

  assign txf.busy = busy;
  assign txf.done = bit_end && (bit_cnt == LAST_BIT);

  // ####################
  // bit timing
  // ####################
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (load)
    begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (bit_cnt == LAST_BIT)
        busy <= 1'b0;  // stop bit is over
      else
        bit_cnt <= bit_cnt + 1'b1;
    end
    else if (busy)
      baud_cnt <= baud_cnt + 1'b1;
  end

  // the level of the next bit is set up at the end of the current one
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tx <= 1'b1;
    else if (load)
      tx <= 1'b0;  // start bit
    else if (bit_end)
    begin
      if (next_is_data)
        tx <= shift_reg[0];  // LSB first
      else if (bit_cnt == PAR_SLOT)
        tx <= parity;  // parity already covers all eight bits here
      else
        tx <= 1'b1;  // stop bit and then idle
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      shift_reg <= txf.data;
      parity    <= 1'b0;
    end
    else if (bit_end && next_is_data)
    begin
      shift_reg <= {1'b0, shift_reg[uart_cfg_pkg::DATA_BITS-1:1]};
      parity    <= parity ^ shift_reg[0];
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds the bridge testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_tb

verilator --binary --timing --assert \
  -f uart_cmd_bridge.f \
  --top-module tb_uart_cmd_bridge \
  -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

# the testbench prints the fail message on any failed check or timeout
if grep -q "=== FAIL ===" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

echo "simulation finished without failures"
exit 0

//--- test/bridge_properties.sv
`timescale 1ns/1ps
`default_nettype none

module bridge_properties (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic busy,
  input logic read_rdy,
  input logic cmd_rdy,
  input logic rx_enable
);

  // ####################
  // sequencer rules
  // ####################

  start_while_idle: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
    else $error("frame start raised while the serializer is busy");

  read_rdy_single: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else $error("read_rdy stayed high for more than one cycle");

  // the host must not see ready while a reply is still expected
  rdy_low_in_read: assert property (@(posedge clk) disable iff (!rst_n) rx_enable |-> !cmd_rdy)
    else $error("cmd_rdy is high while the receiver is enabled");

endmodule

bind cmd_sequencer bridge_properties u_properties (
  .clk       (clk),
  .rst_n     (rst_n),
  .start     (txf.start),
  .busy      (txf.busy),
  .read_rdy  (read_rdy),
  .cmd_rdy   (cmd_rdy),
  .rx_enable (rxf.enable)
);

`default_nettype wire

//--- test/tb_uart_cmd_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd_bridge;

  localparam int BR           = 8;
  localparam int GAP_BITS     = 16;
  localparam int RESET_CYC    = 16;
  localparam int N_RANDOM     = 6;
  localparam int N_TESTS      = 6 + N_RANDOM;
  localparam int WRITE_CYC    = 2 + (2 * uart_cfg_pkg::FRAME_BITS + GAP_BITS) * BR + 2;
  localparam int CMD_LIMIT    = WRITE_CYC + 4 * BR;  // reads finish well inside this
  localparam int SETTLE_CYC   = 2 * BR;
  localparam int WATCHDOG_CYC = RESET_CYC + N_TESTS * (CMD_LIMIT + SETTLE_CYC + 4) + 100;

  typedef struct packed {
    cmd_pkg::cmd_t       cmd;
    uart_cfg_pkg::data_t reply;
    logic                bad_parity;
  } entry_t;

  logic                clk = 1'b0;
  logic                rst_n;
  cmd_pkg::cmd_t       cmd_in;
  logic                cmd_vld;
  logic                rx;
  logic                tx;
  logic                cmd_rdy;
  uart_cfg_pkg::data_t read_data;
  logic                read_rdy;

  entry_t              tests[$];
  int                  seed = 2;
  int                  cycle = 0;
  uart_cfg_pkg::data_t frame_bytes[$];  // bytes decoded from tx
  int                  frame_start[$];
  int                  frame_stop[$];
  int                  reply_req = 0;
  int                  rdy_count = 0;
  uart_cfg_pkg::data_t rdy_data;
  uart_cfg_pkg::data_t reply_byte;
  logic                reply_bad;
  uart_cfg_pkg::data_t exp_read_data = '0;

  uart_cmd_bridge #(
    .BR       (BR),
    .GAP_BITS (GAP_BITS)
  ) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  always @(negedge clk)
  begin
    if (read_rdy === 1'b1)
    begin
      rdy_count = rdy_count + 1;
      rdy_data  = read_data;
    end
  end

  // ####################
  // failure reporting
  // ####################
  task automatic end_with_failure();
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    end_with_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want)
    else
    begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, want);
      end_with_failure();
    end
  endtask

  // ####################
  // remote device model
  // ####################
  initial
  begin : tx_monitor
    uart_cfg_pkg::data_t bits;
    logic                par_bit;
    logic                stop_bit;
    int                  start_cyc;
    logic                data_next;
    data_next = 1'b0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge clk);
      if (tx === 1'b0)
      begin
        start_cyc = cycle;
        repeat (BR / 2) @(negedge clk);  // middle of the start bit
        assert (tx === 1'b0) else abort_run("tx start bit was not low at mid-bit");
        for (int i = 0; i < uart_cfg_pkg::DATA_BITS; i++)
        begin
          repeat (BR) @(negedge clk);
          bits[i] = tx;  // LSB arrives first
        end
        repeat (BR) @(negedge clk);
        par_bit = tx;
        repeat (BR) @(negedge clk);
        stop_bit = tx;
        check_value("tx parity bit", 32'(par_bit), 32'(^bits));
        check_value("tx stop bit", 32'(stop_bit), 32'(1'b1));
        frame_bytes.push_back(bits);
        frame_start.push_back(start_cyc);
        frame_stop.push_back(cycle);
        if (data_next)
          data_next = 1'b0;  // second frame of a write holds the data byte
        else if (bits[cmd_pkg::RW_BIT - uart_cfg_pkg::DATA_BITS] == cmd_pkg::CMD_READ)
          reply_req = reply_req + 1;
        else
          data_next = 1'b1;
      end
    end
  end

  task automatic drive_bit(input logic value);
    rx = value;
    repeat (BR) @(negedge clk);
  endtask

  initial
  begin : remote_responder
    int                  served;
    uart_cfg_pkg::data_t byte_out;
    logic                par;
    served = 0;
    rx     = 1'b1;
    forever
    begin
      wait (reply_req > served);
      served   = served + 1;
      byte_out = reply_byte;
      par      = (^byte_out) ^ reply_bad;  // a flipped bit breaks even parity
      repeat (2 * BR) @(negedge clk);      // turnaround of the remote device
      drive_bit(1'b0);
      for (int i = 0; i < uart_cfg_pkg::DATA_BITS; i++)
        drive_bit(byte_out[i]);
      drive_bit(par);
      drive_bit(1'b1);
    end
  end

  // ####################
  // stimulus table
  // ####################
  task automatic add_test(input cmd_pkg::cmd_t cmd, input uart_cfg_pkg::data_t reply,
                          input logic bad);
    entry_t e;
    e.cmd        = cmd;
    e.reply      = reply;
    e.bad_parity = bad;
    tests.push_back(e);
  endtask

  task automatic fill_tests();
    add_test(16'h925A, 8'h00, 1'b0);  // write 0x5a to 0x12
    add_test(16'h1200, 8'hA5, 1'b0);
    add_test(16'h3400, 8'h3C, 1'b1);  // reply is dropped
    add_test(16'hFF00, 8'h00, 1'b0);
    add_test(16'h7F00, 8'hFF, 1'b0);
    add_test(16'h0100, 8'h81, 1'b1);
    for (int i = 0; i < N_RANDOM; i++)
      add_test(cmd_pkg::cmd_t'($random(seed)), uart_cfg_pkg::data_t'($random(seed)),
               1'($random(seed)));
  endtask

  task automatic run_command(input entry_t e);
    int   base;
    int   pulses;
    int   elapsed;
    int   gap;
    logic is_write;
    logic good_read;
    base       = frame_bytes.size();
    pulses     = rdy_count;
    is_write   = (e.cmd[cmd_pkg::RW_BIT] == cmd_pkg::CMD_WRITE);
    good_read  = !is_write && !e.bad_parity;
    reply_byte = e.reply;
    reply_bad  = e.bad_parity;
    check_value("cmd_rdy", 32'(cmd_rdy), 32'(1'b1));
    cmd_in  = e.cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    check_value("cmd_rdy", 32'(cmd_rdy), 32'(1'b0));
    elapsed = 0;
    while (cmd_rdy !== 1'b1)
    begin
      @(negedge clk);
      elapsed = elapsed + 1;
      if (elapsed == 3)
      begin
        cmd_in  = ~e.cmd;  // must be ignored while busy
        cmd_vld = 1'b1;
      end
      else if (elapsed == 4)
        cmd_vld = 1'b0;
      assert (elapsed <= CMD_LIMIT)
      else abort_run($sformatf("command 0x%0h did not finish within %0d cycles",
                               e.cmd, CMD_LIMIT));
    end
    check_value("tx frame count", 32'(frame_bytes.size() - base), 32'(is_write ? 2 : 1));
    check_value("tx high byte", 32'(frame_bytes[base]), 32'(e.cmd[15:8]));
    if (is_write)
    begin
      assert (elapsed <= WRITE_CYC)
      else abort_run($sformatf("write took %0d cycles, more than %0d", elapsed, WRITE_CYC));
      check_value("tx low byte", 32'(frame_bytes[base+1]), 32'(e.cmd[7:0]));
      gap = frame_start[base+1] - frame_stop[base] - BR / 2;  // idle time after the stop bit
      assert (gap >= GAP_BITS * BR)
      else abort_run($sformatf("tx idle gap was %0d cycles, less than %0d",
                               gap, GAP_BITS * BR));
    end
    if (good_read)
    begin
      exp_read_data = e.reply;
      check_value("read_data at read_rdy", 32'(rdy_data), 32'(e.reply));
    end
    check_value("read_rdy pulses", 32'(rdy_count - pulses), 32'(good_read ? 1 : 0));
    check_value("read_data", 32'(read_data), 32'(exp_read_data));
    repeat (SETTLE_CYC) @(negedge clk);
  endtask

  // ####################
  // main sequence
  // ####################
  initial
  begin
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rst_n   = 1'b0;
    fill_tests();
    repeat (RESET_CYC) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("tx", 32'(tx), 32'(1'b1));
    check_value("cmd_rdy", 32'(cmd_rdy), 32'(1'b1));
    check_value("read_rdy", 32'(read_rdy), 32'(1'b0));
    check_value("read_data", 32'(read_data), 32'(0));
    foreach (tests[i])
      run_command(tests[i]);
    $display("=== PASS ===");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    abort_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYC));
  end

endmodule

`default_nettype wire

//--- uart_cmd_bridge.f
hdl/uart_cfg_pkg.sv
hdl/cmd_pkg.sv
hdl/frame_ifs.sv
hdl/uart_tx_frame.sv
hdl/uart_rx_frame.sv
hdl/cmd_sequencer.sv
hdl/uart_cmd_bridge.sv
test/bridge_properties.sv
test/tb_uart_cmd_bridge.sv
